//--- dv/ahb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model #(
    parameter int MEM_WORDS = 1024,
    parameter int SEED      = 32'h7622_611f
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           stall_en_i,
    input  wire decomp_dma_pkg::ahb_req_t req_i,
    output decomp_dma_pkg::ahb_rsp_t      rsp_o,
    output int                            err_cnt_o,
    output int                            burst_cnt_o
);

    logic [31:0] mem [0:MEM_WORDS-1];
    logic        hgrant;
    logic        hready;
    logic        dp_valid;
    logic        dp_write;
    logic [31:0] dp_addr;
    logic [31:0] last_addr;
    logic        last_write;
    int          beat_cnt;
    int          grant_dly;
    int          seed;

    // fill pattern from the whole byte address
    initial begin
        logic [31:0] a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i << 2;
            mem[i] = a ^ (a << 16) ^ 32'h5a5a_0000;
        end
        seed        = SEED;
        hgrant      = 1'b0;
        hready      = 1'b1;
        grant_dly   = 2;
        err_cnt_o   = 0;
        burst_cnt_o = 0;
        beat_cnt    = 0;
        dp_valid    = 1'b0;
    end

    function automatic int widx(input logic [31:0] addr);
        return (addr >> 2) % MEM_WORDS;
    endfunction

    assign rsp_o = '{hgrant: hgrant, hready: hready,
                     hrdata: (dp_valid && !dp_write) ? mem[widx(dp_addr)] : 32'h0};

    //----------------------------------------
    // grant delay and wait states
    //----------------------------------------
    always @(negedge clk) begin
        hready = stall_en_i ? (($random(seed) & 3) != 0) : 1'b1;
        if (req_i.hbusreq) begin
            if (grant_dly == 0) begin
                hgrant = 1'b1;
            end else begin
                grant_dly--;
            end
        end else begin
            hgrant    = 1'b0;
            grant_dly = $random(seed) & 7;
        end
    end

    //----------------------------------------
    // address/data pipeline and burst checks
    //----------------------------------------
    always @(posedge clk) begin
        if (rst_n && hready) begin
            if (dp_valid && dp_write) begin
                mem[widx(dp_addr)] <= req_i.hwdata;
            end
            dp_valid <= req_i.htrans != decomp_dma_pkg::HTRANS_IDLE;
            dp_write <= req_i.hwrite;
            dp_addr  <= req_i.haddr;

            if (req_i.htrans == decomp_dma_pkg::HTRANS_NONSEQ) begin
                assert (beat_cnt == 0) else begin
                    $display("FAIL %0t NONSEQ inside an open burst", $time);
                    err_cnt_o++;
                end
                beat_cnt   = 1;
                last_addr  = req_i.haddr;
                last_write = req_i.hwrite;
            end else if (req_i.htrans == decomp_dma_pkg::HTRANS_SEQ) begin
                assert (beat_cnt != 0 && beat_cnt < 16) else begin
                    $display("FAIL %0t SEQ beat %0d outside a burst", $time, beat_cnt);
                    err_cnt_o++;
                end
                assert (req_i.haddr == last_addr + 4) else begin
                    $display("FAIL %0t address %h after %h", $time, req_i.haddr, last_addr);
                    err_cnt_o++;
                end
                assert (req_i.hwrite == last_write) else begin
                    $display("FAIL %0t hwrite changed within burst", $time);
                    err_cnt_o++;
                end
                beat_cnt++;
                last_addr = req_i.haddr;
            end else if (beat_cnt != 0) begin
                assert (beat_cnt == 16) else begin
                    $display("FAIL %0t burst of %0d beats", $time, beat_cnt);
                    err_cnt_o++;
                end
                burst_cnt_o++;
                beat_cnt = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_decomp_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decomp_dma;

    logic                          clk;
    logic                          rst_n;
    logic                          start;
    logic                          stall_en;
    logic                          decomp_done;
    logic                          done;
    decomp_dma_pkg::dma_cmd_t      cmd;
    decomp_dma_pkg::ahb_req_t      ahb_req;
    decomp_dma_pkg::ahb_rsp_t      ahb_rsp;
    decomp_dma_pkg::decomp_wr_t    dwr;
    decomp_dma_pkg::buf_addr_t     buf_addr;
    decomp_dma_pkg::buf_word_t     buf_rdata;

    logic [31:0] src_img [0:1023];
    logic [31:0] dec_buf [0:15];
    logic [3:0]  fill_idx;
    int          seed;
    int          errors;
    int          bus_errors;
    int          bursts;
    int          feed_base;
    int          feed_cnt;
    int          done_dly;
    bit          done_pend;
    bit          timed_out;
    bit          ok;

    decomp_dma_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (cmd),
        .start_i       (start),
        .done_o        (done),
        .ahb_req_o     (ahb_req),
        .ahb_rsp_i     (ahb_rsp),
        .decomp_wr_o   (dwr),
        .decomp_done_i (decomp_done),
        .buf_addr_o    (buf_addr),
        .buf_rdata_i   (buf_rdata)
    );

    ahb_mem_model mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_en_i  (stall_en),
        .req_i       (ahb_req),
        .rsp_o       (ahb_rsp),
        .err_cnt_o   (bus_errors),
        .burst_cnt_o (bursts)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //----------------------------------------
    // reference model
    //----------------------------------------
    function automatic decomp_dma_pkg::lane_mask_t header_lane(input logic [31:0] hdr);
        if (hdr[31]) begin
            return 3'b001;
        end else if (!hdr[30]) begin
            return 3'b010;
        end
        return 3'b100;
    endfunction

    // word i of expanded block b from the source word index
    function automatic logic [31:0] expanded_word(input int src_idx, input int b, input int i);
        logic [31:0] w;
        w = src_img[src_idx + b * 16 + i / 2];
        return (i % 2 == 1) ? ~w : w;
    endfunction

    //----------------------------------------
    // decoder lanes and output buffer
    //----------------------------------------
    assign buf_rdata = {dec_buf[buf_addr], ~dec_buf[buf_addr]};

    always @(negedge clk) begin
        decomp_done = 1'b0;
        if (!rst_n) begin
            fill_idx  = '0;
            done_pend = 1'b0;
        end else begin
            if (done_pend) begin
                if (done_dly == 0) begin
                    decomp_done = 1'b1;
                    done_pend   = 1'b0;
                end else begin
                    done_dly--;
                end
            end
            if (dwr.lane != '0) begin
                dec_buf[fill_idx] = dwr.wdata;
                fill_idx++;
                if (dwr.eop) begin
                    done_dly  = 1 + ($random(seed) & 7);
                    done_pend = 1'b1;
                end
            end
        end
    end

    // feed stream against the source image
    always @(negedge clk) begin
        if (dwr.lane != '0) begin
            assert (dwr.wdata == src_img[feed_base + feed_cnt]) else begin
                $display("FAIL %0t feed word %0d is %h", $time, feed_cnt, dwr.wdata);
                errors++;
            end
            assert (dwr.lane == header_lane(src_img[feed_base + (feed_cnt & ~15)])) else begin
                $display("FAIL %0t feed word %0d on lane %b", $time, feed_cnt, dwr.lane);
                errors++;
            end
            assert (dwr.sop == (feed_cnt % 16 == 0) && dwr.eop == (feed_cnt % 16 == 15))
            else begin
                $display("FAIL %0t feed word %0d sop %b eop %b",
                         $time, feed_cnt, dwr.sop, dwr.eop);
                errors++;
            end
            feed_cnt++;
        end
    end

    task automatic run_cmd(input logic [31:0] src, input logic [31:0] dst,
                           input int len, input bit stall, output bit fine);
        int start_bursts;
        int cycles;
        start_bursts = bursts;
        feed_base    = src >> 2;
        feed_cnt     = 0;
        fine         = 1'b1;
        @(negedge clk);
        stall_en = stall;
        cmd      = '{src: src, dst: dst, len: decomp_dma_pkg::blk_count_t'(len)};
        start    = 1'b1;
        @(posedge clk);
        assert (done == 1'b0) else begin
            $display("FAIL %0t done_o high during start", $time);
            errors++;
        end
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!done && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout waiting for done_o after %0d-block command", len);
            fine = 1'b0;
        end else begin
            assert (feed_cnt == 16 * len) else begin
                $display("FAIL %0t fed %0d words for %0d blocks", $time, feed_cnt, len);
                errors++;
            end
            assert (bursts - start_bursts == 3 * len) else begin
                $display("FAIL %0t %0d bursts for %0d blocks",
                         $time, bursts - start_bursts, len);
                errors++;
            end
        end
    endtask

    task automatic check_dest(input logic [31:0] src, input logic [31:0] dst, input int len);
        logic [31:0] got;
        for (int b = 0; b < len; b++) begin
            for (int i = 0; i < 32; i++) begin
                got = mem.mem[(dst >> 2) + b * 32 + i];
                assert (got == expanded_word(src >> 2, b, i)) else begin
                    $display("FAIL %0t block %0d dst word %0d is %h", $time, b, i, got);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        seed        = 32'h7622_611f;
        errors      = 0;
        timed_out   = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        stall_en    = 1'b0;
        decomp_done = 1'b0;
        cmd         = '0;
        feed_base   = 0;
        feed_cnt    = 0;
        for (int i = 0; i < 16; i++) begin
            dec_buf[i] = '0;
        end

        // random source, then headers chosen to hit every lane
        for (int i = 0; i < 1024; i++) begin
            src_img[i] = $random(seed);
        end
        src_img[16][31:30]  = 2'b01;
        src_img[64][31:30]  = 2'b10;
        src_img[80][31:30]  = 2'b00;
        src_img[96][31:30]  = 2'b11;

        repeat (16) @(negedge clk);
        // source blocks over the memory fill
        for (int i = 16; i < 112; i++) begin
            mem.mem[i] = src_img[i];
        end
        rst_n = 1'b1;

        begin : run_tests
            @(posedge clk);
            assert (!ahb_req.hbusreq && ahb_req.htrans == decomp_dma_pkg::HTRANS_IDLE &&
                    dwr.lane == '0 && done) else begin
                $display("FAIL %0t outputs not idle after reset", $time);
                errors++;
            end

            // zero-length start is dropped
            @(negedge clk);
            cmd   = '{src: 32'h40, dst: 32'h400, len: 0};
            start = 1'b1;
            @(posedge clk);
            assert (done) else begin
                $display("FAIL %0t done_o low on zero-length start", $time);
                errors++;
            end
            @(negedge clk);
            start = 1'b0;
            repeat (20) begin
                @(posedge clk);
                assert (!ahb_req.hbusreq && done) else begin
                    $display("FAIL %0t activity after zero-length start", $time);
                    errors++;
                end
            end

            run_cmd(32'h40, 32'h400, 1, 1'b0, ok);
            if (!ok) begin
                timed_out = 1'b1;
                disable run_tests;
            end
            check_dest(32'h40, 32'h400, 1);

            run_cmd(32'h100, 32'h800, 3, 1'b1, ok);
            if (!ok) begin
                timed_out = 1'b1;
                disable run_tests;
            end
            check_dest(32'h100, 32'h800, 3);
            repeat (4) @(negedge clk);
        end

        $display("errors: testbench %0d, bus %0d, timeout %0d", errors, bus_errors, timed_out);
        if (errors == 0 && bus_errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/ahb_burst_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "decomp_dma_defs.svh"

module ahb_burst_master (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire decomp_dma_pkg::burst_cmd_t burst_cmd_i,
    input  wire decomp_dma_pkg::ahb_rsp_t   ahb_rsp_i,
    output logic                            hbusreq_o,
    output decomp_dma_pkg::addr_t           haddr_o,
    output decomp_dma_pkg::htrans_e         htrans_o,
    output logic                            hwrite_o,
    output logic                            rd_beat_o,
    output logic                            wr_accept_o,
    output logic                            burst_done_o
);

    localparam decomp_dma_pkg::beat_t LAST_BEAT =
        decomp_dma_pkg::beat_t'(`DMA_BEATS_PER_BURST - 1);

    decomp_dma_pkg::burst_state_e state_q, state_n;
    decomp_dma_pkg::beat_t        addr_cnt_q, addr_cnt_n;
    decomp_dma_pkg::addr_t        haddr_q, haddr_n;
    decomp_dma_pkg::htrans_e      htrans_q, htrans_n;
    logic                         hbusreq_q, hbusreq_n;
    logic                         hwrite_q, hwrite_n;
    logic                         hready;

    assign hready = ahb_rsp_i.hready;

    //----------------------------------------
    // address phase pipeline
    // addr_cnt is the index of the address on the bus
    //----------------------------------------
    always_comb begin
        state_n    = state_q;
        addr_cnt_n = addr_cnt_q;
        haddr_n    = haddr_q;
        htrans_n   = htrans_q;
        hbusreq_n  = hbusreq_q;
        hwrite_n   = hwrite_q;

        case (state_q)
            decomp_dma_pkg::BST_IDLE: begin
                if (burst_cmd_i.go) begin
                    hbusreq_n = 1'b1;
                    haddr_n   = burst_cmd_i.base;
                    hwrite_n  = burst_cmd_i.write;
                    state_n   = decomp_dma_pkg::BST_BUSREQ;
                end
            end
            decomp_dma_pkg::BST_BUSREQ: begin
                if (ahb_rsp_i.hgrant) begin
                    htrans_n = decomp_dma_pkg::HTRANS_NONSEQ;
                    state_n  = decomp_dma_pkg::BST_FIRST_ADDR;
                end
            end
            decomp_dma_pkg::BST_FIRST_ADDR: begin
                if (hready) begin
                    haddr_n    = haddr_q + `DMA_BEAT_BYTES;
                    htrans_n   = decomp_dma_pkg::HTRANS_SEQ;
                    addr_cnt_n = decomp_dma_pkg::beat_t'(1);
                    state_n    = decomp_dma_pkg::BST_MIDDLE;
                end
            end
            decomp_dma_pkg::BST_MIDDLE: begin
                // address of this beat and data of the previous one
                if (hready) begin
                    addr_cnt_n = addr_cnt_q + 1'b1;
                    // release the bus after the 14th address
                    if (addr_cnt_q == LAST_BEAT - 2) begin
                        hbusreq_n = 1'b0;
                    end
                    if (addr_cnt_q == LAST_BEAT) begin
                        htrans_n = decomp_dma_pkg::HTRANS_IDLE;
                        state_n  = decomp_dma_pkg::BST_LAST_DATA;
                    end else begin
                        haddr_n = haddr_q + `DMA_BEAT_BYTES;
                    end
                end
            end
            decomp_dma_pkg::BST_LAST_DATA: begin
                if (hready) begin
                    state_n = decomp_dma_pkg::BST_IDLE;
                end
            end
            default: begin
                state_n = decomp_dma_pkg::BST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= decomp_dma_pkg::BST_IDLE;
            addr_cnt_q <= '0;
            htrans_q   <= decomp_dma_pkg::HTRANS_IDLE;
            hbusreq_q  <= 1'b0;
            hwrite_q   <= 1'b0;
        end else begin
            state_q    <= state_n;
            addr_cnt_q <= addr_cnt_n;
            htrans_q   <= htrans_n;
            hbusreq_q  <= hbusreq_n;
            hwrite_q   <= hwrite_n;
        end
    end

    always_ff @(posedge clk) begin
        haddr_q <= haddr_n;
    end

    assign hbusreq_o    = hbusreq_q;
    assign haddr_o      = haddr_q;
    assign htrans_o     = htrans_q;
    assign hwrite_o     = hwrite_q;
    assign rd_beat_o    = !hwrite_q && hready &&
                          (state_q == decomp_dma_pkg::BST_MIDDLE ||
                           state_q == decomp_dma_pkg::BST_LAST_DATA);
    assign wr_accept_o  = hwrite_q && hready &&
                          (state_q == decomp_dma_pkg::BST_FIRST_ADDR ||
                           state_q == decomp_dma_pkg::BST_MIDDLE);
    assign burst_done_o = hready && (state_q == decomp_dma_pkg::BST_LAST_DATA);

    // block controller waits for burst_done before the next go
    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
        burst_cmd_i.go |-> state_q == decomp_dma_pkg::BST_IDLE);

    // only the last two addresses may run after the request drops
    a_seq_busreq: assert property (@(posedge clk) disable iff (!rst_n)
        htrans_q == decomp_dma_pkg::HTRANS_SEQ |-> hbusreq_q || addr_cnt_q >= LAST_BEAT - 1);

endmodule

`default_nettype wire

//--- hw/decoder_feed.sv
`timescale 1ns/1ps
`default_nettype none

`include "decomp_dma_defs.svh"

module decoder_feed (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        rd_beat_i,
    input  wire decomp_dma_pkg::word_t hrdata_i,
    output decomp_dma_pkg::decomp_wr_t decomp_wr_o
);

    localparam decomp_dma_pkg::beat_t LAST_BEAT =
        decomp_dma_pkg::beat_t'(`DMA_BEATS_PER_BURST - 1);

    decomp_dma_pkg::beat_t      beat_q;
    decomp_dma_pkg::lane_mask_t lane_q;
    decomp_dma_pkg::lane_mask_t lane_sel;
    decomp_dma_pkg::lane_mask_t stb_q;
    decomp_dma_pkg::word_t      wdata_q;
    logic                       sop_q;
    logic                       eop_q;

    // lane comes from the two top bits of the block header
    always_comb begin
        lane_sel = lane_q;
        if (beat_q == '0) begin
            if (hrdata_i[`DMA_ADDR_W-1]) begin
                lane_sel = decomp_dma_pkg::lane_mask_t'(1);
            end else if (!hrdata_i[`DMA_ADDR_W-2]) begin
                lane_sel = decomp_dma_pkg::lane_mask_t'(1) << 1;
            end else begin
                lane_sel = decomp_dma_pkg::lane_mask_t'(1) << 2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_q <= '0;
            lane_q <= '0;
            stb_q  <= '0;
            sop_q  <= 1'b0;
            eop_q  <= 1'b0;
        end else begin
            stb_q <= rd_beat_i ? lane_sel : '0;
            sop_q <= rd_beat_i && (beat_q == '0);
            eop_q <= rd_beat_i && (beat_q == LAST_BEAT);
            if (rd_beat_i) begin
                // wraps at the end of each read burst
                beat_q <= beat_q + 1'b1;
                lane_q <= lane_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_beat_i) begin
            wdata_q <= hrdata_i;
        end
    end

    assign decomp_wr_o = '{lane: stb_q, sop: sop_q, eop: eop_q, wdata: wdata_q};

    a_lane_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(decomp_wr_o.lane));

endmodule

`default_nettype wire

//--- hw/decomp_dma_defs.svh
`ifndef DECOMP_DMA_DEFS_SVH
`define DECOMP_DMA_DEFS_SVH

// bus address and data width
`define DMA_ADDR_W 32

// burst geometry
// one burst is 16 beats of 4 bytes
`define DMA_BEATS_PER_BURST 16
`define DMA_BEAT_BYTES 4

// compressed block is 64 bytes
`define DMA_BLK_SHIFT 6

// decoder side
`define DMA_LANES 3
// 16 entries of 64 bits per expanded block
`define DMA_BUF_AW 4

`endif

//--- hw/decomp_dma_pkg.sv
`default_nettype none

`include "decomp_dma_defs.svh"

package decomp_dma_pkg;

    typedef logic [`DMA_ADDR_W-1:0]                 addr_t;
    typedef logic [`DMA_ADDR_W-1:0]                 word_t;
    // block count lives in the address bits above the block offset
    typedef logic [`DMA_ADDR_W-`DMA_BLK_SHIFT-1:0]  blk_count_t;
    typedef logic [2*`DMA_ADDR_W-1:0]               buf_word_t;
    typedef logic [`DMA_BUF_AW-1:0]                 buf_addr_t;
    typedef logic [$clog2(`DMA_BEATS_PER_BURST)-1:0] beat_t;
    typedef logic [`DMA_LANES-1:0]                  lane_mask_t;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // per-block sequence
    typedef enum logic [2:0] {
        BLK_IDLE,
        BLK_READ,
        BLK_DECODE,
        BLK_WRITE_LO,
        BLK_WRITE_HI
    } blk_state_e;

    // one arbitrated burst
    typedef enum logic [2:0] {
        BST_IDLE,
        BST_BUSREQ,
        BST_FIRST_ADDR,
        BST_MIDDLE,
        BST_LAST_DATA
    } burst_state_e;

    typedef struct packed {
        addr_t      src;
        addr_t      dst;
        blk_count_t len;
    } dma_cmd_t;

    typedef struct packed {
        logic    hbusreq;
        addr_t   haddr;
        htrans_e htrans;
        logic    hwrite;
        word_t   hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic  hgrant;
        logic  hready;
        word_t hrdata;
    } ahb_rsp_t;

    typedef struct packed {
        logic  go;
        logic  write;
        addr_t base;
    } burst_cmd_t;

    typedef struct packed {
        lane_mask_t lane;
        logic       sop;
        logic       eop;
        word_t      wdata;
    } decomp_wr_t;

endpackage

`default_nettype wire

//--- hw/decomp_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module decomp_dma_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire decomp_dma_pkg::dma_cmd_t  cmd_i,
    input  wire                            start_i,
    output logic                           done_o,
    output decomp_dma_pkg::ahb_req_t       ahb_req_o,
    input  wire decomp_dma_pkg::ahb_rsp_t  ahb_rsp_i,
    output decomp_dma_pkg::decomp_wr_t     decomp_wr_o,
    input  wire                            decomp_done_i,
    output decomp_dma_pkg::buf_addr_t      buf_addr_o,
    input  wire decomp_dma_pkg::buf_word_t buf_rdata_i
);

    decomp_dma_pkg::burst_cmd_t burst_cmd;
    decomp_dma_pkg::addr_t      haddr;
    decomp_dma_pkg::htrans_e    htrans;
    decomp_dma_pkg::word_t      hwdata;
    logic                       hbusreq;
    logic                       hwrite;
    logic                       burst_done;
    logic                       rd_beat;
    logic                       wr_accept;

    dma_block_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (cmd_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .burst_cmd_o   (burst_cmd),
        .burst_done_i  (burst_done),
        .decomp_done_i (decomp_done_i)
    );

    ahb_burst_master u_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .burst_cmd_i  (burst_cmd),
        .ahb_rsp_i    (ahb_rsp_i),
        .hbusreq_o    (hbusreq),
        .haddr_o      (haddr),
        .htrans_o     (htrans),
        .hwrite_o     (hwrite),
        .rd_beat_o    (rd_beat),
        .wr_accept_o  (wr_accept),
        .burst_done_o (burst_done)
    );

    decoder_feed u_feed (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_beat_i   (rd_beat),
        .hrdata_i    (ahb_rsp_i.hrdata),
        .decomp_wr_o (decomp_wr_o)
    );

    writeback_unpack u_unpack (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_accept_i (wr_accept),
        .buf_rdata_i (buf_rdata_i),
        .buf_addr_o  (buf_addr_o),
        .hwdata_o    (hwdata)
    );

    // bus request from master control and writeback data
    assign ahb_req_o = '{hbusreq: hbusreq, haddr: haddr, htrans: htrans,
                         hwrite: hwrite, hwdata: hwdata};

endmodule

`default_nettype wire

//--- hw/dma_block_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "decomp_dma_defs.svh"

module dma_block_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire decomp_dma_pkg::dma_cmd_t  cmd_i,
    input  wire                            start_i,
    output logic                           done_o,
    output decomp_dma_pkg::burst_cmd_t     burst_cmd_o,
    input  wire                            burst_done_i,
    input  wire                            decomp_done_i
);

    decomp_dma_pkg::blk_state_e state_q, state_n;
    decomp_dma_pkg::blk_count_t blk_idx_q, blk_idx_n;
    decomp_dma_pkg::blk_count_t blk_next;
    decomp_dma_pkg::dma_cmd_t   cmd_q;
    decomp_dma_pkg::addr_t      base_q, base_n;
    decomp_dma_pkg::addr_t      src_off;
    decomp_dma_pkg::addr_t      dst_off;
    logic                       go_q, go_n;
    logic                       write_q, write_n;
    logic                       start_ok;

    // zero-length commands are dropped
    assign start_ok = start_i && (cmd_i.len != '0);
    assign blk_next = blk_idx_q + 1'b1;

    // source moves 64 bytes per block, destination 128
    assign src_off = decomp_dma_pkg::addr_t'(blk_next) << `DMA_BLK_SHIFT;
    assign dst_off = decomp_dma_pkg::addr_t'(blk_idx_q) << (`DMA_BLK_SHIFT + 1);

    //----------------------------------------
    // block sequencer
    //----------------------------------------
    always_comb begin
        state_n   = state_q;
        blk_idx_n = blk_idx_q;
        base_n    = base_q;
        write_n   = write_q;
        go_n      = 1'b0;

        case (state_q)
            decomp_dma_pkg::BLK_IDLE: begin
                if (start_ok) begin
                    blk_idx_n = '0;
                    base_n    = cmd_i.src;
                    write_n   = 1'b0;
                    go_n      = 1'b1;
                    state_n   = decomp_dma_pkg::BLK_READ;
                end
            end
            decomp_dma_pkg::BLK_READ: begin
                if (burst_done_i) begin
                    state_n = decomp_dma_pkg::BLK_DECODE;
                end
            end
            decomp_dma_pkg::BLK_DECODE: begin
                if (decomp_done_i) begin
                    base_n  = cmd_q.dst + dst_off;
                    write_n = 1'b1;
                    go_n    = 1'b1;
                    state_n = decomp_dma_pkg::BLK_WRITE_LO;
                end
            end
            decomp_dma_pkg::BLK_WRITE_LO: begin
                if (burst_done_i) begin
                    // second half of the expanded block
                    base_n  = base_q + (decomp_dma_pkg::addr_t'(1) << `DMA_BLK_SHIFT);
                    go_n    = 1'b1;
                    state_n = decomp_dma_pkg::BLK_WRITE_HI;
                end
            end
            decomp_dma_pkg::BLK_WRITE_HI: begin
                if (burst_done_i) begin
                    blk_idx_n = blk_next;
                    if (blk_next == cmd_q.len) begin
                        state_n = decomp_dma_pkg::BLK_IDLE;
                    end else begin
                        base_n  = cmd_q.src + src_off;
                        write_n = 1'b0;
                        go_n    = 1'b1;
                        state_n = decomp_dma_pkg::BLK_READ;
                    end
                end
            end
            default: begin
                state_n = decomp_dma_pkg::BLK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= decomp_dma_pkg::BLK_IDLE;
            blk_idx_q <= '0;
            write_q   <= 1'b0;
            go_q      <= 1'b0;
        end else begin
            state_q   <= state_n;
            blk_idx_q <= blk_idx_n;
            write_q   <= write_n;
            go_q      <= go_n;
        end
    end

    always_ff @(posedge clk) begin
        base_q <= base_n;
        if (state_q == decomp_dma_pkg::BLK_IDLE && start_ok) begin
            cmd_q <= cmd_i;
        end
    end

    assign done_o      = (state_q == decomp_dma_pkg::BLK_IDLE) && !start_ok;
    assign burst_cmd_o = '{go: go_q, write: write_q, base: base_q};

    // decoders only finish a block that was fed to them
    a_done_in_decode: assert property (@(posedge clk) disable iff (!rst_n)
        decomp_done_i |-> state_q == decomp_dma_pkg::BLK_DECODE);

endmodule

`default_nettype wire

//--- hw/writeback_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "decomp_dma_defs.svh"

module writeback_unpack (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            wr_accept_i,
    input  wire decomp_dma_pkg::buf_word_t buf_rdata_i,
    output decomp_dma_pkg::buf_addr_t      buf_addr_o,
    output decomp_dma_pkg::word_t          hwdata_o
);

    // write beat within the block, 0 to 31 over both bursts
    logic [`DMA_BUF_AW:0]  wb_cnt_q;
    decomp_dma_pkg::word_t hwdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_cnt_q <= '0;
        end else if (wr_accept_i) begin
            wb_cnt_q <= wb_cnt_q + 1'b1;
        end
    end

    // even beat takes the upper half, odd beat the lower
    always_ff @(posedge clk) begin
        if (wr_accept_i) begin
            if (wb_cnt_q[0]) begin
                hwdata_q <= buf_rdata_i[`DMA_ADDR_W-1:0];
            end else begin
                hwdata_q <= buf_rdata_i[2*`DMA_ADDR_W-1:`DMA_ADDR_W];
            end
        end
    end

    assign buf_addr_o = wb_cnt_q[`DMA_BUF_AW:1];
    assign hwdata_o   = hwdata_q;

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/decomp_dma_pkg.sv
hw/dma_block_ctrl.sv
hw/ahb_burst_master.sv
hw/decoder_feed.sv
hw/writeback_unpack.sv
hw/decomp_dma_top.sv
dv/ahb_mem_model.sv
dv/tb_decomp_dma.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_decomp_dma

out=$(./obj_dir/Vtb_decomp_dma)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
